/* hdl/rv_exec_macros.svh */
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// data word width.
`define RV_XLEN 32

// byte addressed instruction space.
`define RV_IADDR_BITS 16

// architectural integer registers including x0.
`define RV_NREGS 32

`endif

/* hdl/rv_exec_pkg.sv */
`include "rv_exec_macros.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0]            xlen_t;
    // halfword aligned so bit 0 is implied zero.
    typedef logic [`RV_IADDR_BITS-1:1]      pc_t;
    typedef logic [$clog2(`RV_NREGS)-1:0]   reg_idx_t;
    typedef logic [2:0]                     funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_OP2
    } alu_op_e;

    typedef enum logic {
        RES_ALU,
        RES_LINK
    } res_src_e;

    // decoded instruction as delivered by the decoder.
    typedef struct packed {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        xlen_t      imm;
        funct3_t    funct3;
        alu_op_e    alu_op;
        res_src_e   res_src;
        logic       reg_write;
        logic       op1_pc;
        logic       op2_imm;
        logic       inst_jal;
        logic       inst_jalr;
        logic       inst_branch;
        logic       inst_mret;
        logic       to_trap;
        pc_t        pc;
        pc_t        pc_next;
    } dec_pkt_t;

    // control and target leaving the operand stage.
    typedef struct packed {
        reg_idx_t   rd;
        alu_op_e    alu_op;
        res_src_e   res_src;
        logic       reg_write;
        funct3_t    funct3;
        logic       inst_jal;
        logic       inst_jalr;
        logic       inst_branch;
        logic       inst_mret;
        logic       to_trap;
        pc_t        pc_next;
        pc_t        pc_target;
    } ex_pkt_t;

    typedef struct packed {
        logic       we;
        reg_idx_t   rd;
        xlen_t      data;
    } wb_pkt_t;

    typedef struct packed {
        logic       valid;
        pc_t        target;
    } redirect_t;

endpackage

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

`include "rv_exec_macros.svh"

module rv_regfile
    import rv_exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  wb_pkt_t     i_wb,
    input  reg_idx_t    i_raddr1,
    input  reg_idx_t    i_raddr2,
    output xlen_t       o_rdata1,
    output xlen_t       o_rdata2
);

    // x0 has no storage.
    xlen_t regs [1:`RV_NREGS-1];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < `RV_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wb.we && (i_wb.rd != '0))
        begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // pending write wins over the stored value.
    function automatic xlen_t read_port(input reg_idx_t idx);
        xlen_t val;
        if (idx == '0)
            val = '0;
        else if (i_wb.we && (i_wb.rd == idx))
            val = i_wb.data;
        else
            val = regs[idx];
        return val;
    endfunction

    always_comb
    begin
        o_rdata1 = read_port(i_raddr1);
        o_rdata2 = read_port(i_raddr2);
    end

endmodule

/* hdl/rv_operand_stage.sv */
`timescale 1ns/1ps

`include "rv_exec_macros.svh"

module rv_operand_stage
    import rv_exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_flush,
    input  logic        i_stall,
    input  dec_pkt_t    i_dec,
    input  xlen_t       i_rdata1,
    input  xlen_t       i_rdata2,
    input  pc_t         i_ret_addr,
    output reg_idx_t    o_rs1,
    output reg_idx_t    o_rs2,
    output xlen_t       o_op1,
    output xlen_t       o_op2,
    output ex_pkt_t     o_ex,
    output xlen_t       o_rs1_data
);

    logic       reg_write;
    logic       inst_jal;
    logic       inst_jalr;
    logic       inst_branch;
    logic       inst_mret;
    logic       to_trap;

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    xlen_t      imm;
    funct3_t    funct3;
    alu_op_e    alu_op;
    res_src_e   res_src;
    logic       op1_pc;
    logic       op2_imm;
    pc_t        pc;
    pc_t        pc_next;

    logic [`RV_IADDR_BITS-1:0] target_base;
    logic [`RV_IADDR_BITS-1:0] target_offset;
    logic [`RV_IADDR_BITS-1:0] target_sum;

    // control bits clear to a bubble.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            reg_write   <= 1'b0;
            inst_jal    <= 1'b0;
            inst_jalr   <= 1'b0;
            inst_branch <= 1'b0;
            inst_mret   <= 1'b0;
            to_trap     <= 1'b0;
        end
        else if (i_flush)
        begin
            reg_write   <= 1'b0;
            inst_jal    <= 1'b0;
            inst_jalr   <= 1'b0;
            inst_branch <= 1'b0;
            inst_mret   <= 1'b0;
            to_trap     <= 1'b0;
        end
        else if (!i_stall)
        begin
            reg_write   <= i_dec.reg_write;
            inst_jal    <= i_dec.inst_jal;
            inst_jalr   <= i_dec.inst_jalr;
            inst_branch <= i_dec.inst_branch;
            inst_mret   <= i_dec.inst_mret;
            to_trap     <= i_dec.to_trap;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            rs1     <= i_dec.rs1;
            rs2     <= i_dec.rs2;
            rd      <= i_dec.rd;
            imm     <= i_dec.imm;
            funct3  <= i_dec.funct3;
            alu_op  <= i_dec.alu_op;
            res_src <= i_dec.res_src;
            op1_pc  <= i_dec.op1_pc;
            op2_imm <= i_dec.op2_imm;
            pc      <= i_dec.pc;
            pc_next <= i_dec.pc_next;
        end
    end

    assign o_op1 = op1_pc ? {{(`RV_XLEN-`RV_IADDR_BITS){1'b0}}, pc, 1'b0} : i_rdata1;
    assign o_op2 = op2_imm ? imm : i_rdata2;

    // full byte add so jalr gets the carry out of bit 0.
    assign target_base   = inst_mret ? {i_ret_addr, 1'b0} :
                           inst_jalr ? i_rdata1[`RV_IADDR_BITS-1:0] :
                           {pc, 1'b0};
    assign target_offset = inst_mret ? '0 : imm[`RV_IADDR_BITS-1:0];
    assign target_sum    = target_base + target_offset;

    assign o_rs1      = rs1;
    assign o_rs2      = rs2;
    assign o_rs1_data = i_rdata1;

    assign o_ex = '{
        rd:          rd,
        alu_op:      alu_op,
        res_src:     res_src,
        reg_write:   reg_write,
        funct3:      funct3,
        inst_jal:    inst_jal,
        inst_jalr:   inst_jalr,
        inst_branch: inst_branch,
        inst_mret:   inst_mret,
        to_trap:     to_trap,
        pc_next:     pc_next,
        pc_target:   target_sum[`RV_IADDR_BITS-1:1]
    };

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

`include "rv_exec_macros.svh"

module rv_alu
    import rv_exec_pkg::*;
(
    input  xlen_t       i_op1,
    input  xlen_t       i_op2,
    input  alu_op_e     i_alu_op,
    input  xlen_t       i_rs1_data,
    input  funct3_t     i_funct3,
    output xlen_t       o_result,
    output logic        o_cmp_taken
);

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    logic [4:0] shamt;
    logic       op_lt_s;
    logic       op_lt_u;
    logic       cmp_eq;
    logic       cmp_lt_s;
    logic       cmp_lt_u;

    assign shamt   = i_op2[4:0];
    assign op_lt_s = $signed(i_op1) < $signed(i_op2);
    assign op_lt_u = i_op1 < i_op2;

    always_comb
    begin
        case (i_alu_op)
            ALU_ADD:      o_result = i_op1 + i_op2;
            ALU_SUB:      o_result = i_op1 - i_op2;
            ALU_AND:      o_result = i_op1 & i_op2;
            ALU_OR:       o_result = i_op1 | i_op2;
            ALU_XOR:      o_result = i_op1 ^ i_op2;
            ALU_SLL:      o_result = i_op1 << shamt;
            ALU_SRL:      o_result = i_op1 >> shamt;
            ALU_SRA:      o_result = $unsigned($signed(i_op1) >>> shamt);
            ALU_SLT:      o_result = {{(`RV_XLEN-1){1'b0}}, op_lt_s};
            ALU_SLTU:     o_result = {{(`RV_XLEN-1){1'b0}}, op_lt_u};
            ALU_PASS_OP2: o_result = i_op2;
            default:      o_result = '0;
        endcase
    end

    // branches keep op2 on rs2 data.
    assign cmp_eq   = i_rs1_data == i_op2;
    assign cmp_lt_s = $signed(i_rs1_data) < $signed(i_op2);
    assign cmp_lt_u = i_rs1_data < i_op2;

    always_comb
    begin
        case (i_funct3)
            F3_BEQ:  o_cmp_taken = cmp_eq;
            F3_BNE:  o_cmp_taken = !cmp_eq;
            F3_BLT:  o_cmp_taken = cmp_lt_s;
            F3_BGE:  o_cmp_taken = !cmp_lt_s;
            F3_BLTU: o_cmp_taken = cmp_lt_u;
            F3_BGEU: o_cmp_taken = !cmp_lt_u;
            default: o_cmp_taken = 1'b0;
        endcase
    end

endmodule

/* hdl/rv_commit_stage.sv */
`timescale 1ns/1ps

`include "rv_exec_macros.svh"

module rv_commit_stage
    import rv_exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_stall,
    input  ex_pkt_t     i_ex,
    input  xlen_t       i_result,
    input  logic        i_cmp_taken,
    output wb_pkt_t     o_wb,
    output redirect_t   o_redirect,
    output logic        o_trap
);

    logic       we_q;
    logic       redirect_q;
    logic       trap_q;
    reg_idx_t   rd_q;
    xlen_t      data_q;
    pc_t        target_q;

    xlen_t      link_data;
    logic       take_redirect;

    assign link_data     = {{(`RV_XLEN-`RV_IADDR_BITS){1'b0}}, i_ex.pc_next, 1'b0};
    assign take_redirect = i_ex.inst_jal | i_ex.inst_jalr | i_ex.inst_mret |
                           (i_ex.inst_branch & i_cmp_taken);

    // a stalled operand stage hands over a bubble.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            we_q       <= 1'b0;
            redirect_q <= 1'b0;
            trap_q     <= 1'b0;
        end
        else
        begin
            we_q       <= !i_stall && i_ex.reg_write && (i_ex.rd != '0);
            redirect_q <= !i_stall && take_redirect;
            trap_q     <= !i_stall && i_ex.to_trap;
        end
    end

    always_ff @(posedge i_clk)
    begin
        rd_q     <= i_ex.rd;
        data_q   <= (i_ex.res_src == RES_LINK) ? link_data : i_result;
        target_q <= i_ex.pc_target;
    end

    assign o_wb       = '{we: we_q, rd: rd_q, data: data_q};
    assign o_redirect = '{valid: redirect_q, target: target_q};
    assign o_trap     = trap_q;

endmodule

/* hdl/rv_exec_top.sv */
`timescale 1ns/1ps

module rv_exec_top
    import rv_exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_flush,
    input  logic        i_stall,
    input  dec_pkt_t    i_dec,
    input  pc_t         i_ret_addr,
    output wb_pkt_t     o_wb,
    output redirect_t   o_redirect,
    output logic        o_trap
);

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      rdata1;
    xlen_t      rdata2;
    xlen_t      op1;
    xlen_t      op2;
    xlen_t      rs1_data;
    ex_pkt_t    ex;
    xlen_t      result;
    logic       cmp_taken;

    // the commit output doubles as the write port.
    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (o_wb),
        .i_raddr1   (rs1),
        .i_raddr2   (rs2),
        .o_rdata1   (rdata1),
        .o_rdata2   (rdata2)
    );

    rv_operand_stage u_operand (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_stall    (i_stall),
        .i_dec      (i_dec),
        .i_rdata1   (rdata1),
        .i_rdata2   (rdata2),
        .i_ret_addr (i_ret_addr),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_op1      (op1),
        .o_op2      (op2),
        .o_ex       (ex),
        .o_rs1_data (rs1_data)
    );

    rv_alu u_alu (
        .i_op1       (op1),
        .i_op2       (op2),
        .i_alu_op    (ex.alu_op),
        .i_rs1_data  (rs1_data),
        .i_funct3    (ex.funct3),
        .o_result    (result),
        .o_cmp_taken (cmp_taken)
    );

    rv_commit_stage u_commit (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_ex        (ex),
        .i_result    (result),
        .i_cmp_taken (cmp_taken),
        .o_wb        (o_wb),
        .o_redirect  (o_redirect),
        .o_trap      (o_trap)
    );

endmodule

/* test/rv_exec_chk.sv */
`timescale 1ns/1ps

module rv_exec_chk
    import rv_exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  wb_pkt_t     i_wb,
    input  redirect_t   i_redirect,
    input  logic        i_trap
);

    // quiet outputs while in reset.
    a_reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |-> (!i_wb.we && !i_redirect.valid))
        else $error("writeback or redirect active during reset");

    a_trap_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_trap |=> !i_trap)
        else $error("trap held high for more than one cycle");

    // x0 has no storage.
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb.we |-> (i_wb.rd != '0))
        else $error("writeback targets register x0");

endmodule

bind rv_exec_top rv_exec_chk u_chk (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wb       (o_wb),
    .i_redirect (o_redirect),
    .i_trap     (o_trap)
);

/* test/rv_exec_tb.sv */
`timescale 1ns/1ps

`include "rv_exec_macros.svh"

module rv_exec_tb
    import rv_exec_pkg::*;
();

    localparam int NCOL        = 26;
    localparam int MAX_ROWS    = 64;
    localparam int DRAIN_LIMIT = 8;

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic       stall;
    dec_pkt_t   dec;
    pc_t        ret_addr;
    wb_pkt_t    wb;
    redirect_t  redirect;
    logic       trap;

    // one row of NCOL words per instruction.
    logic [31:0] stim [0:NCOL*MAX_ROWS-1];

    rv_exec_top uut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_flush    (flush),
        .i_stall    (stall),
        .i_dec      (dec),
        .i_ret_addr (ret_addr),
        .o_wb       (wb),
        .o_redirect (redirect),
        .o_trap     (trap)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            stop_run($sformatf("ERR %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic drive_idle();
        stall    = 1'b0;
        flush    = 1'b0;
        dec      = '0;
        ret_addr = '0;
    endtask

    // addresses in the file are byte addresses.
    task automatic drive_row(input int row);
        int base;
        base            = row * NCOL;
        stall           = stim[base][0];
        flush           = stim[base+1][0];
        dec.rs1         = stim[base+2][4:0];
        dec.rs2         = stim[base+3][4:0];
        dec.rd          = stim[base+4][4:0];
        dec.imm         = stim[base+5];
        dec.funct3      = stim[base+6][2:0];
        dec.alu_op      = alu_op_e'(stim[base+7][3:0]);
        dec.res_src     = res_src_e'(stim[base+8][0]);
        dec.reg_write   = stim[base+9][0];
        dec.op1_pc      = stim[base+10][0];
        dec.op2_imm     = stim[base+11][0];
        dec.inst_jal    = stim[base+12][0];
        dec.inst_jalr   = stim[base+13][0];
        dec.inst_branch = stim[base+14][0];
        dec.inst_mret   = stim[base+15][0];
        dec.to_trap     = stim[base+16][0];
        dec.pc          = stim[base+17][`RV_IADDR_BITS-1:1];
        dec.pc_next     = stim[base+18][`RV_IADDR_BITS-1:1];
        ret_addr        = stim[base+19][`RV_IADDR_BITS-1:1];
    endtask

    task automatic verify_row(input int row);
        int base;
        base = row * NCOL;
        check_value($sformatf("row %0d o_wb.we", row), {31'b0, wb.we}, stim[base+20]);
        check_value($sformatf("row %0d o_trap", row), {31'b0, trap}, stim[base+25]);
        check_value($sformatf("row %0d o_redirect.valid", row), {31'b0, redirect.valid},
                    stim[base+23]);
        if (stim[base+20][0])
        begin
            check_value($sformatf("row %0d o_wb.rd", row), {27'b0, wb.rd}, stim[base+21]);
            check_value($sformatf("row %0d o_wb.data", row), wb.data, stim[base+22]);
        end
        if (stim[base+23][0])
        begin
            check_value($sformatf("row %0d o_redirect.target", row),
                        {{(`RV_XLEN-`RV_IADDR_BITS){1'b0}}, redirect.target, 1'b0},
                        stim[base+24]);
        end
    endtask

    initial
    begin
        int nrows;
        int row;
        int checked;
        int cycles;
        int idx;
        int pending[$];

        rst_n = 1'b0;
        drive_idle();
        // rows never read keep a marker that no stall column can hold.
        for (int i = 0; i < NCOL * MAX_ROWS; i++)
        begin
            stim[i] = {16'hbad0, i[15:0]};
        end
        $readmemh("test/rv_exec_input.txt", stim);
        nrows = 0;
        while (nrows < MAX_ROWS && stim[nrows * NCOL] <= 32'd1)
        begin
            nrows++;
        end
        if (nrows == 0)
        begin
            stop_run("no stimulus rows found in test/rv_exec_input.txt");
        end

        repeat (3) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        row     = 0;
        checked = 0;
        cycles  = 0;

        // each row is checked two edges after it is driven.
        while (checked < nrows)
        begin
            if (cycles > nrows + DRAIN_LIMIT)
            begin
                stop_run("timeout: not every instruction reached the outputs in time");
            end
            if (pending.size() == 2)
            begin
                idx = pending.pop_front();
                if (idx >= 0)
                begin
                    verify_row(idx);
                    checked++;
                end
            end
            if (row < nrows)
            begin
                drive_row(row);
                pending.push_back(row);
                row++;
            end
            else
            begin
                drive_idle();
                pending.push_back(-1);
            end
            cycles++;
            @(posedge clk);
            #1;
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* test/rv_exec_input.txt */
// stall flush rs1 rs2 rd imm funct3 alu_op res_src reg_write op1_pc op2_imm jal jalr branch mret
// to_trap pc pc_next ret_addr (bytes) | expected two edges on: we rd data valid target trap
0 0 00 00 01 00000005 0 0 0 1 0 1 0 0 0 0 0 0100 0104 0200 1 01 00000005 0 0000 0
0 0 00 00 02 fffffff9 0 0 0 1 0 1 0 0 0 0 0 0104 0108 0200 1 02 fffffff9 0 0000 0
0 0 01 02 03 00000000 0 0 0 1 0 0 0 0 0 0 0 0108 010c 0200 1 03 fffffffe 0 0000 0
0 0 01 02 04 00000000 0 1 0 1 0 0 0 0 0 0 0 010c 0110 0200 1 04 0000000c 0 0000 0
0 0 03 04 05 00000000 0 2 0 1 0 0 0 0 0 0 0 0110 0114 0200 1 05 0000000c 0 0000 0
0 0 01 04 06 00000000 0 3 0 1 0 0 0 0 0 0 0 0114 0118 0200 1 06 0000000d 0 0000 0
0 0 02 00 07 000000f0 0 4 0 1 0 1 0 0 0 0 0 0118 011c 0200 1 07 ffffff09 0 0000 0
0 0 01 00 08 00000004 0 5 0 1 0 1 0 0 0 0 0 011c 0120 0200 1 08 00000050 0 0000 0
0 0 02 00 09 0000001c 0 6 0 1 0 1 0 0 0 0 0 0120 0124 0200 1 09 0000000f 0 0000 0
0 0 02 00 0a 00000001 0 7 0 1 0 1 0 0 0 0 0 0124 0128 0200 1 0a fffffffc 0 0000 0
0 0 02 01 0b 00000000 0 8 0 1 0 0 0 0 0 0 0 0128 012c 0200 1 0b 00000001 0 0000 0
0 0 02 01 0c 00000000 0 9 0 1 0 0 0 0 0 0 0 012c 0130 0200 1 0c 00000000 0 0000 0
0 0 01 00 00 00000007 0 0 0 1 0 1 0 0 0 0 0 0130 0134 0200 0 00 00000000 0 0000 0
0 0 00 00 01 00000020 0 0 1 1 0 0 1 0 0 0 0 0134 0138 0200 1 01 00000138 1 0154 0
0 0 01 00 0e 00000007 0 0 1 1 0 1 0 1 0 0 0 0154 0158 0200 1 0e 00000158 1 013e 0
0 0 04 05 00 00000040 0 0 0 0 0 0 0 0 1 0 0 013e 0142 0200 0 00 00000000 1 017e 0
0 0 01 02 00 00000010 4 0 0 0 0 0 0 0 1 0 0 017e 0182 0200 0 00 00000000 0 0000 0
0 0 02 01 00 fffffff0 7 0 0 0 0 0 0 0 1 0 0 0182 0186 0200 0 00 00000000 1 0172 0
0 0 01 00 0f 00000001 0 0 0 1 0 1 0 0 0 0 0 0172 0176 0200 0 00 00000000 0 0000 0
1 0 00 00 1f 00000055 0 0 0 1 0 1 0 0 0 0 0 0176 017a 0200 1 0f 00000139 0 0000 0
0 0 0f 01 10 00000000 0 0 0 1 0 0 0 0 0 0 0 0176 017a 0200 1 10 00000271 0 0000 0
0 0 00 00 00 00000000 0 0 0 0 0 0 0 0 0 1 0 017a 017e 0200 0 00 00000000 1 0200 0
0 0 00 00 00 00000000 0 0 0 0 0 0 0 0 0 0 1 0200 0204 0200 0 00 00000000 0 0000 1
0 1 00 00 11 00000040 0 0 1 1 0 0 1 0 0 0 0 0204 0208 0200 0 00 00000000 0 0000 0
0 0 11 00 12 00000003 0 0 0 1 0 1 0 0 0 0 0 0208 020c 0200 1 12 00000003 0 0000 0

/* sim.f */
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/rv_regfile.sv
hdl/rv_operand_stage.sv
hdl/rv_alu.sv
hdl/rv_commit_stage.sv
hdl/rv_exec_top.sv
test/rv_exec_chk.sv
test/rv_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

# run from the project root so relative paths resolve.
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv_exec_tb -Mdir obj_dir -o rv_exec_sim -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv_exec_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
